// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= tb_id_stage
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_id_stage.sv ====
// Directed testbench for the RV32I decode stage
// Drives fetch words and controller levels, checks the ID/EX word against encoding rules

`timescale 1ns/1ps
`include "id_defines.svh"

module tb_id_stage import id_pipe_pkg::*; ();

  // Major opcodes from the RV32I base encoding
  localparam logic [6:0] MAJ_OP_IMM = 7'h13;
  localparam logic [6:0] MAJ_OP     = 7'h33;
  localparam logic [6:0] MAJ_STORE  = 7'h23;
  localparam logic [6:0] MAJ_BRANCH = 7'h63;
  localparam logic [6:0] MAJ_JAL    = 7'h6f;
  localparam logic [6:0] MAJ_JALR   = 7'h67;
  // Ten transfers of about four cycles each plus stalls, wide margin
  localparam int         MAX_CYCLES = 400;

  logic        clk;
  logic        rst_n;
  if_id_t      if_id;
  ctrl_byp_t   ctrl_byp;
  ctrl_fsm_t   ctrl_fsm;
  logic [31:0] rf_rdata_a;
  logic [31:0] rf_rdata_b;
  logic [31:0] rf_wdata_ex;
  logic [31:0] rf_wdata_wb;
  logic        ex_ready;
  logic [1:0]  rf_re;
  logic [4:0]  rf_raddr_a;
  logic [4:0]  rf_raddr_b;
  logic [31:0] jmp_target;
  logic        alu_jmp;
  id_ex_t      id_ex;
  logic        id_valid;
  logic        id_ready;

  // Random register data of the current instruction
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] ex_data;
  logic [31:0] wb_data;
  logic [31:0] lfsr;
  int          err_count   = 0;
  int          check_count = 0;
  int          cycle_count = 0;

  id_stage UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_i       (if_id),
    .ctrl_byp_i    (ctrl_byp),
    .ctrl_fsm_i    (ctrl_fsm),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rf_wdata_ex_i (rf_wdata_ex),
    .rf_wdata_wb_i (rf_wdata_wb),
    .ex_ready_i    (ex_ready),
    .rf_re_o       (rf_re),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .jmp_target_o  (jmp_target),
    .alu_jmp_o     (alu_jmp),
    .id_ex_o       (id_ex),
    .id_valid_o    (id_valid),
    .id_ready_o    (id_ready)
  );

  always #50 clk = ~clk;

  // Watchdog on a hung handshake
  always @(posedge clk) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("Timeout: no result after %0d clock cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    lfsr_step = {1'b0, state[31:1]};
    if (state[0]) begin
      lfsr_step = lfsr_step ^ 32'h8020_0003;
    end
  endfunction

  // One LFSR step per bit
  task automatic rand_word(output logic [31:0] word);
    word = '0;
    for (int i = 0; i < 32; i++) begin
      word = {word[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Instruction formats built from the field layout
  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    enc_i = {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, MAJ_OP};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], MAJ_STORE};
  endfunction

  // B-type scrambles imm[12|10:5] and imm[4:1|11]
  function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], MAJ_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, MAJ_JAL};
  endfunction

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("CHECK FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Present a valid word with fresh register and forward data
  task automatic issue(input logic [31:0] word, input logic [31:0] pc);
    @(posedge clk);
    rand_word(rs1_data);
    rand_word(rs2_data);
    rand_word(ex_data);
    rand_word(wb_data);
    if_id.instr_valid <= 1'b1;
    if_id.pc          <= pc;
    if_id.instr       <= word;
    rf_rdata_a        <= rs1_data;
    rf_rdata_b        <= rs2_data;
    rf_wdata_ex       <= ex_data;
    rf_wdata_wb       <= wb_data;
  endtask

  // Poll the handshake at negedge, drop valid on the transfer edge
  task automatic wait_transfer();
    @(negedge clk);
    while (!(id_valid && ex_ready)) begin
      @(negedge clk);
    end
    @(posedge clk);
    if_id.instr_valid <= 1'b0;
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_alu_ops();
    logic [31:0] imm;
    imm = 32'hffff_fff9;
    // ADDI x5, x3, -7
    issue(enc_i(imm, 5'd3, 3'b000, 5'd5, MAJ_OP_IMM), 32'h0000_1000);
    wait_transfer();
    check_val("ADDI instr_valid", id_ex.instr_valid, 1);
    check_val("ADDI operand_a", id_ex.operand_a, rs1_data);
    check_val("ADDI operand_b", id_ex.operand_b, imm);
    check_val("ADDI rf_we", id_ex.rf_we, 1);
    check_val("ADDI rf_waddr", id_ex.rf_waddr, 5);
    check_val("ADDI alu_operator", id_ex.alu_operator, ALU_ADD);
    check_val("ADDI pc", id_ex.pc, 32'h0000_1000);
    // Only rs1 is read for an I-type word
    check_val("ADDI rf_re_o", rf_re, 2'b01);
    check_val("ADDI rf_raddr_a_o", rf_raddr_a, 3);
    // ADD x7, x1, x2
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd7), 32'h0000_1004);
    wait_transfer();
    check_val("ADD operand_a", id_ex.operand_a, rs1_data);
    check_val("ADD operand_b", id_ex.operand_b, rs2_data);
    check_val("ADD rf_waddr", id_ex.rf_waddr, 7);
    check_val("ADD alu_operator", id_ex.alu_operator, ALU_ADD);
    check_val("ADD rf_re_o", rf_re, 2'b11);
    check_val("ADD rf_raddr_a_o", rf_raddr_a, 1);
    check_val("ADD rf_raddr_b_o", rf_raddr_b, 2);
  endtask

  task automatic test_forwarding();
    issue(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd9), 32'h0000_2000);
    ctrl_byp.operand_a_fw_sel <= SEL_FW_EX;
    ctrl_byp.operand_b_fw_sel <= SEL_FW_WB;
    wait_transfer();
    check_val("forward operand_a", id_ex.operand_a, ex_data);
    check_val("forward operand_b", id_ex.operand_b, wb_data);
    @(posedge clk);
    ctrl_byp <= '0;
  endtask

  task automatic test_store_branch();
    logic [31:0] imm;
    imm = 32'hffff_ffec;
    // SW x9, -20(x4)
    issue(enc_s(imm, 5'd9, 5'd4, 3'b010), 32'h0000_3000);
    wait_transfer();
    check_val("SW operand_a", id_ex.operand_a, rs1_data);
    check_val("SW operand_b", id_ex.operand_b, imm);
    check_val("SW operand_c", id_ex.operand_c, rs2_data);
    check_val("SW lsu_en", id_ex.lsu_en, 1);
    check_val("SW lsu_we", id_ex.lsu_we, 1);
    check_val("SW lsu_size", id_ex.lsu_size, 2'b10);
    check_val("SW rf_we", id_ex.rf_we, 0);
    check_val("SW rf_raddr_b_o", rf_raddr_b, 9);
    // BNE x1, x2, -2044
    imm = 32'hffff_f804;
    issue(enc_b(imm, 5'd2, 5'd1, 3'b001), 32'h0000_4000);
    wait_transfer();
    check_val("BNE operand_c", id_ex.operand_c, 32'h0000_4000 + imm);
    check_val("BNE alu_bch", id_ex.alu_bch, 1);
    check_val("BNE alu_operator", id_ex.alu_operator, ALU_NE);
  endtask

  task automatic test_jumps();
    logic [31:0] imm;
    imm = 32'h0001_2344;
    issue(enc_j(imm, 5'd1), 32'h0000_8000);
    wait_transfer();
    // Word and PC stay on the inputs, so the target is still valid
    check_val("JAL jmp_target", jmp_target, 32'h0000_8000 + imm);
    check_val("JAL alu_jmp_o", alu_jmp, 1);
    check_val("JAL alu_jmp", id_ex.alu_jmp, 1);
    check_val("JAL rf_re_o", rf_re, 2'b00);
    check_val("JAL operand_a", id_ex.operand_a, 32'h0000_8000);
    check_val("JAL operand_b", id_ex.operand_b, 4);
    check_val("JAL rf_waddr", id_ex.rf_waddr, 1);
    // JALR x1, 13(x6), odd offset exercises bit 0 clear
    imm = 32'h0000_000d;
    issue(enc_i(imm, 5'd6, 3'b000, 5'd1, MAJ_JALR), 32'h0000_9000);
    wait_transfer();
    check_val("JALR jmp_target", jmp_target, (rs1_data + imm) & 32'hffff_fffe);
    check_val("JALR operand_a", id_ex.operand_a, 32'h0000_9000);
    check_val("JALR operand_b", id_ex.operand_b, 4);
  endtask

  task automatic test_stall_halt();
    id_ex_t      held;
    logic [31:0] word_b;
    logic [31:0] word_c;
    word_b = enc_r(7'h20, 5'd11, 5'd10, 3'b000, 5'd12);
    word_c = enc_i(32'h0000_0123, 5'd2, 3'b110, 5'd8, MAJ_OP_IMM);
    // SUB waits while EX is stalled
    issue(word_b, 32'h0000_0200);
    ex_ready <= 1'b0;
    @(negedge clk);
    held = id_ex;
    repeat (3) begin
      @(negedge clk);
      check_val("stall id_ready_o", id_ready, 0);
      check_val("stall id_ex_o held", id_ex == held, 1);
    end
    @(posedge clk);
    ex_ready <= 1'b1;
    wait_transfer();
    check_val("stall SUB instr", id_ex.instr, word_b);
    check_val("stall SUB operand_b", id_ex.operand_b, rs2_data);
    check_val("stall SUB alu_operator", id_ex.alu_operator, ALU_SUB);
    // ORI moves, then halt turns the held word into a bubble
    issue(word_c, 32'h0000_0204);
    @(negedge clk);
    check_val("halt pre id_valid_o", id_valid, 1);
    @(posedge clk);
    ctrl_fsm.halt_id <= 1'b1;
    @(negedge clk);
    check_val("halt id_valid_o", id_valid, 0);
    check_val("halt id_ready_o", id_ready, 0);
    check_val("halt ORI moved", id_ex.instr_valid, 1);
    @(negedge clk);
    check_val("halt instr_valid cleared", id_ex.instr_valid, 0);
    check_val("halt instr held", id_ex.instr, word_c);
    @(posedge clk);
    ctrl_fsm.halt_id  <= 1'b0;
    if_id.instr_valid <= 1'b0;
  endtask

  task automatic test_illegal();
    // Opcode 7'h7f is outside the kept classes
    issue(32'h1234_567f, 32'h0000_0300);
    wait_transfer();
    check_val("illegal instr_valid", id_ex.instr_valid, 1);
    check_val("illegal illegal_insn", id_ex.illegal_insn, 1);
    check_val("illegal rf_we", id_ex.rf_we, 0);
    check_val("illegal alu_en", id_ex.alu_en, 0);
    check_val("illegal lsu_en", id_ex.lsu_en, 0);
  endtask

  initial begin : main
    clk         = 1'b0;
    rst_n       = 1'b0;
    if_id       = '0;
    if_id.instr = `ID_NOP_INSTR;
    ctrl_byp    = '0;
    ctrl_fsm    = '0;
    rf_rdata_a  = '0;
    rf_rdata_b  = '0;
    rf_wdata_ex = '0;
    rf_wdata_wb = '0;
    ex_ready    = 1'b1;
    lfsr        = 32'hf926_8825;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("reset instr_valid", id_ex.instr_valid, 0);
    check_val("reset alu_en", id_ex.alu_en, 0);
    check_val("reset lsu_en", id_ex.lsu_en, 0);
    check_val("reset rf_we", id_ex.rf_we, 0);
    check_val("reset instr", id_ex.instr, `ID_NOP_INSTR);
    test_alu_ops();
    test_forwarding();
    test_store_branch();
    test_jumps();
    test_stall_halt();
    test_illegal();
    @(posedge clk);
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/id_pipe_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_unit.sv
rtl/id_ex_register.sv
rtl/id_stage.sv
dv/tb_id_stage.sv

// ==== rtl/id_decoder.sv ====
// RV32I instruction decoder
// Turns one instruction word into ALU/LSU control, register enables and mux selects

`timescale 1ns/1ps
`include "id_defines.svh"

module id_decoder import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  rv_instr_u  instr_i,
  input  logic       deassert_we_i,
  output id_decode_t dec_o
);

  logic illegal;

  // Base ALU op from funct3, alt picks SUB/SRA
  function automatic alu_op_e alu_op_f3(input funct3_t f3, input logic alt);
    case (f3)
      F3_ADD_SUB: alu_op_f3 = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_op_f3 = ALU_SLL;
      F3_SLT:     alu_op_f3 = ALU_SLT;
      F3_SLTU:    alu_op_f3 = ALU_SLTU;
      F3_XOR:     alu_op_f3 = ALU_XOR;
      F3_SR:      alu_op_f3 = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op_f3 = ALU_OR;
      default:    alu_op_f3 = ALU_AND;
    endcase
  endfunction

  always_comb begin : decode
    // All-zero default is ADD with every select on NONE
    dec_o          = '0;
    dec_o.rf_waddr = instr_i[`ID_RD_MSB:`ID_RD_LSB];
    illegal        = 1'b0;

    case (instr_i.r.opcode)
      OPC_OP: begin
        dec_o.alu_en       = 1'b1;
        dec_o.rf_re        = 2'b11;
        dec_o.rf_we        = 1'b1;
        dec_o.op_a_sel     = OP_A_REG;
        dec_o.op_b_sel     = OP_B_REG;
        dec_o.alu_operator = alu_op_f3(instr_i.r.funct3, instr_i.r.funct7[5]);
        // Only ADD/SUB and SRL/SRA have a second funct7
        if (instr_i.r.funct7 == 7'h20) begin
          illegal = !(instr_i.r.funct3 inside {F3_ADD_SUB, F3_SR});
        end else begin
          illegal = (instr_i.r.funct7 != 7'h00);
        end
      end
      OPC_OP_IMM: begin
        dec_o.alu_en       = 1'b1;
        dec_o.rf_re        = 2'b01;
        dec_o.rf_we        = 1'b1;
        dec_o.op_a_sel     = OP_A_REG;
        dec_o.op_b_sel     = OP_B_IMM;
        dec_o.imm_b_sel    = IMM_I;
        // ADDI has no SUB form, so alt only counts for shifts
        dec_o.alu_operator = alu_op_f3(instr_i.i.funct3,
                                       (instr_i.i.funct3 == F3_SR) && instr_i.i.imm[10]);
        // Shift amount upper bits must be a legal funct7
        if (instr_i.i.funct3 == F3_SLL) begin
          illegal = (instr_i.i.imm[11:5] != 7'h00);
        end else if (instr_i.i.funct3 == F3_SR) begin
          illegal = !(instr_i.i.imm[11:5] inside {7'h00, 7'h20});
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        dec_o.alu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = (instr_i.r.opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMM_U;
      end
      OPC_JAL, OPC_JALR: begin
        // ALU forms the link value PC + 4, target comes from the operand unit
        dec_o.alu_en   = 1'b1;
        dec_o.alu_jmp  = 1'b1;
        dec_o.rf_we    = 1'b1;
        dec_o.op_a_sel = OP_A_PC;
        dec_o.op_b_sel = OP_B_PCINCR;
        if (instr_i.r.opcode == OPC_JALR) begin
          dec_o.alu_jmpr = 1'b1;
          dec_o.rf_re    = 2'b01;
          illegal        = (instr_i.i.funct3 != 3'b000);
        end
      end
      OPC_BRANCH: begin
        dec_o.alu_en   = 1'b1;
        dec_o.alu_bch  = 1'b1;
        dec_o.rf_re    = 2'b11;
        dec_o.op_a_sel = OP_A_REG;
        dec_o.op_b_sel = OP_B_REG;
        dec_o.op_c_sel = OP_C_BCH;
        case (instr_i.r.funct3)
          3'b000:  dec_o.alu_operator = ALU_EQ;
          3'b001:  dec_o.alu_operator = ALU_NE;
          3'b100:  dec_o.alu_operator = ALU_LT;
          3'b101:  dec_o.alu_operator = ALU_GE;
          3'b110:  dec_o.alu_operator = ALU_LTU;
          3'b111:  dec_o.alu_operator = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // Address is rs1 + I immediate
        dec_o.lsu_en    = 1'b1;
        dec_o.lsu_size  = instr_i.i.funct3[1:0];
        dec_o.lsu_sext  = !instr_i.i.funct3[2];
        dec_o.rf_re     = 2'b01;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = OP_A_REG;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMM_I;
        // LB LH LW LBU LHU only
        illegal = (instr_i.i.funct3 inside {3'b011, 3'b110, 3'b111});
      end
      OPC_STORE: begin
        // Store data rides on operand C
        dec_o.lsu_en    = 1'b1;
        dec_o.lsu_we    = 1'b1;
        dec_o.lsu_size  = instr_i.s.funct3[1:0];
        dec_o.rf_re     = 2'b11;
        dec_o.op_a_sel  = OP_A_REG;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMM_S;
        dec_o.op_c_sel  = OP_C_REG;
        illegal = instr_i.s.funct3[2] || (instr_i.s.funct3[1:0] == 2'b11);
      end
      default: illegal = 1'b1;
    endcase

    // Illegal word carries no enables and leaves the operands alone
    if (illegal) begin
      dec_o              = '0;
      dec_o.illegal_insn = 1'b1;
    end

    // Controller suppresses side effects, e.g. after an exception
    if (deassert_we_i) begin
      dec_o.rf_we  = 1'b0;
      dec_o.lsu_en = 1'b0;
    end
  end

  // ALU and LSU never both claim one instruction
  a_alu_lsu_excl: assert final (!(dec_o.alu_en && dec_o.lsu_en));

endmodule

// ==== rtl/id_defines.svh ====
// Decode stage constants
// Data width, register field positions and reset values shared by the ID stage

`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Data and register address widths
`define ID_XLEN        32
`define ID_REG_ADDR_W  5

// Register fields inside the 32-bit instruction word
`define ID_RS1_MSB     19
`define ID_RS1_LSB     15
`define ID_RS2_MSB     24
`define ID_RS2_LSB     20
`define ID_RD_MSB      11
`define ID_RD_LSB      7

// ADDI x0,x0,0 held in the ID/EX word after reset
`define ID_NOP_INSTR   32'h0000_0013

// Link offset for JAL/JALR, no compressed support
`define ID_PC_INCR     32'd4

`endif

// ==== rtl/id_ex_register.sv ====
// ID/EX pipeline register
// Stage valid/ready under halt, kill and back-pressure, plus the registered ID/EX word

`timescale 1ns/1ps
`include "id_defines.svh"

module id_ex_register import id_pipe_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  if_id_t       if_id_i,
  input  ctrl_fsm_t    fsm_i,
  input  id_decode_t   dec_i,
  input  id_operands_t opnd_i,
  input  logic         ex_ready_i,
  output logic         id_valid_o,
  output logic         id_ready_o,
  output id_ex_t       id_ex_o
);

  // Halt and kill both turn the slot into a bubble
  assign id_valid_o = if_id_i.instr_valid && !fsm_i.halt_id && !fsm_i.kill_id;
  // Kill drains ID regardless of EX
  assign id_ready_o = fsm_i.kill_id || (ex_ready_i && !fsm_i.halt_id);

  always_ff @(posedge clk or negedge rst_n) begin : id_ex_regs
    if (!rst_n) begin
      id_ex_o       <= '0;
      id_ex_o.instr <= `ID_NOP_INSTR;
    end else if (id_valid_o && ex_ready_i) begin
      id_ex_o.instr_valid <= 1'b1;

      // Operands only move when the instruction uses them
      if (dec_i.op_a_sel != OP_A_NONE) begin
        id_ex_o.operand_a <= opnd_i.operand_a;
      end
      if (dec_i.op_b_sel != OP_B_NONE) begin
        id_ex_o.operand_b <= opnd_i.operand_b;
      end
      if (dec_i.op_c_sel != OP_C_NONE) begin
        id_ex_o.operand_c <= opnd_i.operand_c;
      end

      // Unit fields follow their enable
      id_ex_o.alu_en <= dec_i.alu_en;
      if (dec_i.alu_en) begin
        id_ex_o.alu_bch      <= dec_i.alu_bch;
        id_ex_o.alu_jmp      <= dec_i.alu_jmp;
        id_ex_o.alu_operator <= dec_i.alu_operator;
      end

      id_ex_o.lsu_en <= dec_i.lsu_en;
      if (dec_i.lsu_en) begin
        id_ex_o.lsu_we   <= dec_i.lsu_we;
        id_ex_o.lsu_size <= dec_i.lsu_size;
        id_ex_o.lsu_sext <= dec_i.lsu_sext;
      end

      id_ex_o.rf_we <= dec_i.rf_we;
      if (dec_i.rf_we) begin
        id_ex_o.rf_waddr <= dec_i.rf_waddr;
      end

      id_ex_o.illegal_insn <= dec_i.illegal_insn;
      // PC and word kept for exceptions
      id_ex_o.pc           <= if_id_i.pc;
      id_ex_o.instr        <= if_id_i.instr;
    end else if (ex_ready_i) begin
      // EX took its item and nothing follows
      id_ex_o.instr_valid <= 1'b0;
    end
  end

  // EX stall freezes the whole word
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(id_ex_o));

endmodule

// ==== rtl/id_operand_unit.sv ====
// Operand unit
// Builds immediates, forwards register data, picks operands A/B/C and computes targets

`timescale 1ns/1ps
`include "id_defines.svh"

module id_operand_unit import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  logic [`ID_XLEN-1:0] pc_i,
  input  rv_instr_u           instr_i,
  input  id_decode_t          dec_i,
  input  ctrl_byp_t           byp_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0] rf_wdata_ex_i,
  input  logic [`ID_XLEN-1:0] rf_wdata_wb_i,
  output id_operands_t        opnd_o,
  output logic [`ID_XLEN-1:0] jmp_target_o
);

  logic [`ID_XLEN-1:0] imm_i_type;
  logic [`ID_XLEN-1:0] imm_s_type;
  logic [`ID_XLEN-1:0] imm_b_type;
  logic [`ID_XLEN-1:0] imm_u_type;
  logic [`ID_XLEN-1:0] imm_j_type;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] operand_a_fw;
  logic [`ID_XLEN-1:0] operand_b_fw;
  logic [`ID_XLEN-1:0] jalr_fw;

  // One forward mux, used for rs1, rs2 and the JALR base
  function automatic logic [`ID_XLEN-1:0] fwd_mux(input fw_sel_e             sel,
                                                  input logic [`ID_XLEN-1:0] rf_data,
                                                  input logic [`ID_XLEN-1:0] ex_data,
                                                  input logic [`ID_XLEN-1:0] wb_data);
    case (sel)
      SEL_FW_EX: fwd_mux = ex_data;
      SEL_FW_WB: fwd_mux = wb_data;
      default:   fwd_mux = rf_data;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i_type = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s_type = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  // B-type: imm[12|10:5] in the high field, imm[4:1|11] in the low field
  assign imm_b_type = {{19{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi[6], instr_i.s.imm_lo[0],
                       instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
  assign imm_u_type = {instr_i.u.imm, 12'b0};
  // J-type: imm[20|10:1|11|19:12] packed into the U field
  assign imm_j_type = {{12{instr_i.u.imm[19]}}, instr_i.u.imm[7:0], instr_i.u.imm[8],
                       instr_i.u.imm[18:9], 1'b0};

  // Immediate for operand B
  always_comb begin : imm_b_mux
    case (dec_i.imm_b_sel)
      IMM_S:   imm_b = imm_s_type;
      IMM_U:   imm_b = imm_u_type;
      default: imm_b = imm_i_type;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding and operand muxes
  ////////////////////////////////////////////////////////////////////////////

  assign operand_a_fw = fwd_mux(byp_i.operand_a_fw_sel, rf_rdata_a_i,
                                rf_wdata_ex_i, rf_wdata_wb_i);
  assign operand_b_fw = fwd_mux(byp_i.operand_b_fw_sel, rf_rdata_b_i,
                                rf_wdata_ex_i, rf_wdata_wb_i);
  assign jalr_fw      = fwd_mux(byp_i.jalr_fw_sel, rf_rdata_a_i,
                                rf_wdata_ex_i, rf_wdata_wb_i);

  always_comb begin : operand_a_mux
    case (dec_i.op_a_sel)
      OP_A_PC:   opnd_o.operand_a = pc_i;
      OP_A_ZERO: opnd_o.operand_a = '0;
      default:   opnd_o.operand_a = operand_a_fw;
    endcase
  end

  always_comb begin : operand_b_mux
    case (dec_i.op_b_sel)
      OP_B_IMM:    opnd_o.operand_b = imm_b;
      OP_B_PCINCR: opnd_o.operand_b = `ID_PC_INCR;
      default:     opnd_o.operand_b = operand_b_fw;
    endcase
  end

  // Store data or branch target
  assign opnd_o.operand_c = (dec_i.op_c_sel == OP_C_BCH) ? opnd_o.bch_target : operand_b_fw;

  ////////////////////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////////////////////

  assign opnd_o.bch_target = pc_i + imm_b_type;

  // JALR clears bit 0 of the sum
  assign jmp_target_o = dec_i.alu_jmpr ? ((jalr_fw + imm_i_type) & ~`ID_XLEN'd1)
                                       : (pc_i + imm_j_type);

endmodule

// ==== rtl/id_pipe_pkg.sv ====
// Decode stage pipeline types
// Mux selects, controller inputs and the IF/ID and ID/EX pipeline words

`include "id_defines.svh"

package id_pipe_pkg;

  // ALU operation, base ops then the branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // NONE is encoded as zero so a cleared decode holds the operands
  typedef enum logic [1:0] {OP_A_NONE, OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_NONE, OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_sel_e;
  typedef enum logic [1:0] {OP_C_NONE, OP_C_REG, OP_C_BCH} op_c_sel_e;
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;

  //////////////////////////////////////////////////////////////////////////
  // Stage inputs
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                 instr_valid;
    logic [`ID_XLEN-1:0]  pc;
    logic [`ID_XLEN-1:0]  instr;
  } if_id_t;

  // Forward selects from the hazard logic
  typedef struct packed {
    fw_sel_e operand_a_fw_sel;
    fw_sel_e operand_b_fw_sel;
    fw_sel_e jalr_fw_sel;
    logic    deassert_we;
  } ctrl_byp_t;

  typedef struct packed {
    logic halt_id;
    logic kill_id;
  } ctrl_fsm_t;

  //////////////////////////////////////////////////////////////////////////
  // Internal results and the ID/EX word
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                      alu_en;
    logic                      alu_bch;
    logic                      alu_jmp;
    logic                      alu_jmpr;
    alu_op_e                   alu_operator;
    logic                      lsu_en;
    logic                      lsu_we;
    logic [1:0]                lsu_size;
    logic                      lsu_sext;
    logic [1:0]                rf_re;
    logic                      rf_we;
    logic [`ID_REG_ADDR_W-1:0] rf_waddr;
    logic                      illegal_insn;
    op_a_sel_e                 op_a_sel;
    op_b_sel_e                 op_b_sel;
    imm_sel_e                  imm_b_sel;
    op_c_sel_e                 op_c_sel;
  } id_decode_t;

  typedef struct packed {
    logic [`ID_XLEN-1:0] operand_a;
    logic [`ID_XLEN-1:0] operand_b;
    logic [`ID_XLEN-1:0] operand_c;
    logic [`ID_XLEN-1:0] bch_target;
  } id_operands_t;

  typedef struct packed {
    logic                      instr_valid;
    logic                      alu_en;
    logic                      alu_bch;
    logic                      alu_jmp;
    alu_op_e                   alu_operator;
    logic                      lsu_en;
    logic                      lsu_we;
    logic [1:0]                lsu_size;
    logic                      lsu_sext;
    logic [`ID_XLEN-1:0]       operand_a;
    logic [`ID_XLEN-1:0]       operand_b;
    logic [`ID_XLEN-1:0]       operand_c;
    logic                      rf_we;
    logic [`ID_REG_ADDR_W-1:0] rf_waddr;
    logic                      illegal_insn;
    logic [`ID_XLEN-1:0]       pc;
    logic [`ID_XLEN-1:0]       instr;
  } id_ex_t;

endpackage

// ==== rtl/id_stage.sv ====
// RV32I instruction decode stage
// Decoder and operand unit side by side, both feeding the ID/EX register

`timescale 1ns/1ps
`include "id_defines.svh"

module id_stage import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  if_id_t                    if_id_i,
  input  ctrl_byp_t                 ctrl_byp_i,
  input  ctrl_fsm_t                 ctrl_fsm_i,
  input  logic [`ID_XLEN-1:0]       rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]       rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0]       rf_wdata_ex_i,
  input  logic [`ID_XLEN-1:0]       rf_wdata_wb_i,
  input  logic                      ex_ready_i,
  output logic [1:0]                rf_re_o,
  output logic [`ID_REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [`ID_REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [`ID_XLEN-1:0]       jmp_target_o,
  output logic                      alu_jmp_o,
  output id_ex_t                    id_ex_o,
  output logic                      id_valid_o,
  output logic                      id_ready_o
);

  rv_instr_u    instr;
  id_decode_t   dec;
  id_operands_t opnd;

  assign instr = if_id_i.instr;

  // Register file read side, straight from the word
  assign rf_re_o      = dec.rf_re;
  assign rf_raddr_a_o = if_id_i.instr[`ID_RS1_MSB:`ID_RS1_LSB];
  assign rf_raddr_b_o = if_id_i.instr[`ID_RS2_MSB:`ID_RS2_LSB];
  // Early jump request to fetch
  assign alu_jmp_o    = dec.alu_jmp;

  id_decoder u_decoder (
    .instr_i       (instr),
    .deassert_we_i (ctrl_byp_i.deassert_we),
    .dec_o         (dec)
  );

  id_operand_unit u_operand_unit (
    .pc_i          (if_id_i.pc),
    .instr_i       (instr),
    .dec_i         (dec),
    .byp_i         (ctrl_byp_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .opnd_o        (opnd),
    .jmp_target_o  (jmp_target_o)
  );

  id_ex_register u_id_ex_register (
    .clk        (clk),
    .rst_n      (rst_n),
    .if_id_i    (if_id_i),
    .fsm_i      (ctrl_fsm_i),
    .dec_i      (dec),
    .opnd_i     (opnd),
    .ex_ready_i (ex_ready_i),
    .id_valid_o (id_valid_o),
    .id_ready_o (id_ready_o),
    .id_ex_o    (id_ex_o)
  );

endmodule

// ==== rtl/rv_isa_pkg.sv ====
// RV32I instruction encoding
// Major opcodes, funct3 codes and the field views of one instruction word

package rv_isa_pkg;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_AUIPC  = 7'b001_0111,
    OPC_STORE  = 7'b010_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_JALR   = 7'b110_0111,
    OPC_JAL    = 7'b110_1111
  } opcode_e;

  typedef logic [2:0] funct3_t;

  // ALU funct3 codes, shared by OP and OP-IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SR      = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  //////////////////////////////////////////////////////////////////////////
  // Field layouts, MSB first
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    funct3_t    funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    funct3_t     funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_i_t;

  // B-type shares this layout with its immediate bits scrambled
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    funct3_t    funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } instr_s_t;

  // J-type shares this layout
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_u_t;

  // One word, four readings
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_u_t u;
  } rv_instr_u;

endpackage
